// File: test/ahb_tests.txt
# columns: op(R/W) addr(hex) byte_en(hex) wdata(hex) exp_rdata(hex) exp_err
# exp_rdata is ignored on writes and on reads that expect err 1
# full words in slave 0
W 00000000 f 11223344 00000000 0
W 00000004 f a5a5a5a5 00000000 0
W 00000008 f deadbeef 00000000 0
R 00000000 f 00000000 11223344 0
R 00000004 f 00000000 a5a5a5a5 0
R 00000008 f 00000000 deadbeef 0
W 00000004 f 0badf00d 00000000 0
R 00000004 f 00000000 0badf00d 0
# partial writes, half words then single lanes
W 00000010 f 12345678 00000000 0
W 00000010 3 0000abcd 00000000 0
R 00000010 f 00000000 1234abcd 0
W 00000010 c 99880000 00000000 0
R 00000010 f 00000000 9988abcd 0
W 00000010 1 000000ee 00000000 0
W 00000010 2 0000ff00 00000000 0
W 00000010 4 00770000 00000000 0
W 00000010 8 66000000 00000000 0
R 00000010 f 00000000 6677ffee 0
W 00000014 f cafebabe 00000000 0
W 00000014 2 ffffffff 00000000 0
R 00000014 f 00000000 cafeffbe 0
# odd mask goes out as a full word
W 00000018 f 00000000 00000000 0
W 00000018 5 13572468 00000000 0
R 00000018 f 00000000 13572468 0
# slave 1 with wait states, same offsets as slave 0
W 00001000 f 55aa55aa 00000000 0
W 00001004 f 01020304 00000000 0
R 00001000 f 00000000 55aa55aa 0
R 00001004 f 00000000 01020304 0
W 00001004 c abcd0000 00000000 0
R 00001004 f 00000000 abcd0304 0
R 00000000 f 00000000 11223344 0
R 00000004 f 00000000 0badf00d 0
# unmapped space answers with ERROR and changes nothing
W 00004000 f ffffffff 00000000 1
R 00004000 f 00000000 00000000 1
W 00002000 f 00000000 00000000 1
R 00000000 f 00000000 11223344 0
R 00001000 f 00000000 55aa55aa 0

// File: sim.f
+incdir+logic
logic/ahb_pkg.sv
logic/ahb_master.sv
logic/ahb_decoder.sv
logic/ahb_sram_slave.sv
logic/ahb_subsys_top.sv
test/ahb_subsys_tb.sv

// File: Makefile
# Verilator build and run for the AHB-Lite subsystem.

TOP = ahb_subsys_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  make test   build with Verilator, run, check the log"
	@echo "  make clean  remove build output and the log"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --timescale 1ns/100ps -f sim.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: test/ahb_subsys_tb.sv
// ======================================
// AHB-Lite subsystem testbench
// replays requests from a data file on the
// request port and checks rdata and err.
// ======================================

module ahb_subsys_tb
  import ahb_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_TESTS = 128;     // test table size.

  logic     CLK;
  logic     nRST;
  logic     ren;
  logic     wen;
  addr_t    addr;
  word_t    wdata;
  byte_en_t byte_en;
  logic     busy;
  word_t    rdata;
  logic     err;

  // test table, one entry per data line.
  logic [7:0] t_op    [MAX_TESTS];
  addr_t      t_addr  [MAX_TESTS];
  byte_en_t   t_be    [MAX_TESTS];
  word_t      t_wdata [MAX_TESTS];
  word_t      t_rdata [MAX_TESTS];
  logic       t_err   [MAX_TESTS];

  int num_tests   = 0;
  int mismatches  = 0;                // wrong values.
  int failures    = 0;                // protocol and file problems.
  int cycle_cnt   = 0;
  int cycle_limit = 0;                // zero until the table is loaded.

  ahb_subsys_top i_ahb_subsys_top (
    .CLK     (CLK),
    .nRST    (nRST),
    .ren     (ren),
    .wen     (wen),
    .addr    (addr),
    .wdata   (wdata),
    .byte_en (byte_en),
    .busy    (busy),
    .rdata   (rdata),
    .err     (err)
  );

  // ======================================
  // clock and run limit
  // ======================================

  initial CLK = 1'b0;
  always #5 CLK = ~CLK;               // 10 ns period.

  always @(posedge CLK)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
    begin
      $display("timeout: run still going after %0d cycles", cycle_cnt);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // reads the data file into the test table.
  task automatic load_tests();
    int       fd;
    int       n;
    int       line_no;
    string    line;
    logic [7:0] op;
    addr_t    a;
    byte_en_t be;
    word_t    wd;
    word_t    rd;
    logic     e;
    begin
      line_no = 0;
      fd = $fopen("test/ahb_tests.txt", "r");
      if (fd == 0)
      begin
        failures++;
        $display("error: could not open test/ahb_tests.txt");
        return;
      end
      while ($fgets(line, fd) != 0)
      begin
        line_no++;
        if (line.len() < 2 || line[0] == "#")
          continue;                   // blank or comment line.
        op = line[0];
        n  = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h", a, be, wd, rd, e);
        if (n != 5 || (op != "R" && op != "W") || num_tests >= MAX_TESTS)
        begin
          failures++;
          $display("error: line %0d of the test file is not a usable test", line_no);
        end
        else
        begin
          t_op[num_tests]    = op;
          t_addr[num_tests]  = a;
          t_be[num_tests]    = be;
          t_wdata[num_tests] = wd;
          t_rdata[num_tests] = rd;
          t_err[num_tests]   = e;
          num_tests++;
        end
      end
      $fclose(fd);
    end
  endtask

  // drives one request, waits for its completion cycle, checks it.
  task automatic run_request(input int idx);
    int   waited;
    logic is_read;
    begin
      is_read = (t_op[idx] == "R");
      ren     = is_read;              // held until busy drops.
      wen     = !is_read;
      addr    = t_addr[idx];
      wdata   = t_wdata[idx];
      byte_en = t_be[idx];
      waited  = 0;
      @(negedge CLK);
      waited++;
      while (busy)
      begin
        @(negedge CLK);
        waited++;
      end
      if (waited < 2)
      begin
        failures++;
        $display("error: test %0d finished before any bus transfer could run", idx);
      end
      if (err !== t_err[idx])
      begin
        mismatches++;
        $display("mismatch at %0t: test %0d err %0b, expected %0b",
                 $time, idx, err, t_err[idx]);
      end
      if (is_read && !t_err[idx] && rdata !== t_rdata[idx])
      begin
        mismatches++;
        $display("mismatch at %0t: test %0d rdata %h, expected %h",
                 $time, idx, rdata, t_rdata[idx]);
      end
      ren     = 1'b0;                 // idle cycle between tests.
      wen     = 1'b0;
      addr    = '0;
      wdata   = '0;
      byte_en = '0;
      @(negedge CLK);
      if (busy !== 1'b0 || err !== 1'b0)
      begin
        failures++;
        $display("error: busy or err high with no request after test %0d", idx);
      end
    end
  endtask

  // ======================================
  // main sequence
  // ======================================

  initial
  begin
    nRST    = 1'b0;
    ren     = 1'b0;
    wen     = 1'b0;
    addr    = '0;
    wdata   = '0;
    byte_en = '0;
    load_tests();
    if (num_tests == 0)
    begin
      failures++;
      $display("error: no tests were read from the test file");
    end
    cycle_limit = num_tests * 8 + 100;
    repeat (8) @(negedge CLK);        // reset for 8 cycles.
    nRST = 1'b1;
    @(negedge CLK);
    for (int i = 0; i < num_tests; i++)
      run_request(i);
    $display("tests: %0d, mismatches: %0d, other errors: %0d",
             num_tests, mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: logic/ahb_subsys_top.sv
// ======================================
// AHB-Lite subsystem top
// request bridge, decoder and two SRAMs.
// ======================================

`include "ahb_config.svh"

module ahb_subsys_top
  import ahb_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      ren,
  input  logic      wen,
  input  addr_t     addr,
  input  word_t     wdata,
  input  byte_en_t  byte_en,
  output logic      busy,
  output word_t     rdata,
  output logic      err
);

  // shared master signals.
  addr_t   HADDR;
  htrans_t HTRANS;
  logic    HWRITE;
  hsize_t  HSIZE;
  word_t   HWDATA;

  // decoder returns.
  logic    HREADY;
  word_t   HRDATA;
  hresp_t  HRESP;
  logic    HSEL0, HSEL1;

  // per-slave returns.
  logic    HREADYOUT0, HREADYOUT1;
  word_t   HRDATA0, HRDATA1;
  hresp_t  HRESP0, HRESP1;

  ahb_master i_ahb_master (
    .CLK     (CLK),
    .nRST    (nRST),
    .ren     (ren),
    .wen     (wen),
    .addr    (addr),
    .wdata   (wdata),
    .byte_en (byte_en),
    .busy    (busy),
    .rdata   (rdata),
    .err     (err),
    .HRDATA  (HRDATA),
    .HREADY  (HREADY),
    .HRESP   (HRESP),
    .HADDR   (HADDR),
    .HTRANS  (HTRANS),
    .HWRITE  (HWRITE),
    .HSIZE   (HSIZE),
    .HWDATA  (HWDATA)
  );

  ahb_decoder i_ahb_decoder (
    .CLK        (CLK),
    .nRST       (nRST),
    .HADDR      (HADDR),
    .HTRANS     (HTRANS),
    .HREADYOUT0 (HREADYOUT0),
    .HREADYOUT1 (HREADYOUT1),
    .HRDATA0    (HRDATA0),
    .HRDATA1    (HRDATA1),
    .HRESP0     (HRESP0),
    .HRESP1     (HRESP1),
    .HSEL0      (HSEL0),
    .HSEL1      (HSEL1),
    .HREADY     (HREADY),
    .HRDATA     (HRDATA),
    .HRESP      (HRESP)
  );

  // region offset comes from the low HADDR bits.
  ahb_sram_slave #(
    .WAIT_STATES (`SLAVE0_WAIT),
    .DEPTH       (`SRAM_WORDS)
  ) sram0 (
    .CLK       (CLK),
    .nRST      (nRST),
    .HSEL      (HSEL0),
    .HADDR     (HADDR),
    .HTRANS    (HTRANS),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HWDATA    (HWDATA),
    .HREADY    (HREADY),
    .HREADYOUT (HREADYOUT0),
    .HRDATA    (HRDATA0),
    .HRESP     (HRESP0)
  );

  ahb_sram_slave #(
    .WAIT_STATES (`SLAVE1_WAIT),
    .DEPTH       (`SRAM_WORDS)
  ) sram1 (
    .CLK       (CLK),
    .nRST      (nRST),
    .HSEL      (HSEL1),
    .HADDR     (HADDR),
    .HTRANS    (HTRANS),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HWDATA    (HWDATA),
    .HREADY    (HREADY),
    .HREADYOUT (HREADYOUT1),
    .HRDATA    (HRDATA1),
    .HRESP     (HRESP1)
  );

endmodule

// File: logic/ahb_sram_slave.sv
// ======================================
// AHB-Lite SRAM slave
// word memory with byte-lane writes and
// a fixed number of wait states.
// ======================================

`include "ahb_config.svh"

module ahb_sram_slave
  import ahb_pkg::*;
#(
  parameter int WAIT_STATES = 0,
  parameter int DEPTH       = `SRAM_WORDS
)
(
  input  logic     CLK,
  input  logic     nRST,
  input  logic     HSEL,
  input  addr_t    HADDR,
  input  htrans_t  HTRANS,
  input  logic     HWRITE,
  input  hsize_t   HSIZE,
  input  word_t    HWDATA,
  input  logic     HREADY,
  output logic     HREADYOUT,
  output word_t    HRDATA,
  output hresp_t   HRESP
);

  localparam int IDX_W = $clog2(DEPTH);
  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  word_t            mem [DEPTH];   // storage.
  logic             accept;        // address phase taken.
  logic             active;        // data phase in progress.
  logic             commit;        // write lands this cycle.
  logic             write_q;       // captured HWRITE.
  hsize_t           size_q;        // captured HSIZE.
  logic [1:0]       off_q;         // captured byte offset.
  logic [IDX_W-1:0] idx_q;         // captured word index.
  logic [CNT_W-1:0] wait_cnt;      // wait cycles left.
  byte_en_t         lane_we;       // lanes to write.
  word_t            rdata_q;       // read word.

  assign accept = HSEL && (HTRANS == TRANS_NONSEQ) && HREADY;

  // ======================================
  // data-phase control
  // ======================================

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      active   <= 1'b0;
      wait_cnt <= '0;
    end
    else if (accept)
    begin
      active   <= 1'b1;
      wait_cnt <= CNT_W'(WAIT_STATES);   // load wait count.
    end
    else
    begin
      if (active && wait_cnt == '0)
        active <= 1'b0;                  // data phase done.
      if (wait_cnt != '0)
        wait_cnt <= wait_cnt - CNT_W'(1);
    end
  end

  // address-phase capture and read.
  always_ff @(posedge CLK)
  begin
    if (accept)
    begin
      write_q <= HWRITE;
      size_q  <= HSIZE;
      off_q   <= HADDR[1:0];
      idx_q   <= HADDR[IDX_W+1:2];
      rdata_q <= mem[HADDR[IDX_W+1:2]];  // lanes ignored on reads.
    end
  end

  // ======================================
  // byte-lane write
  // ======================================

  always_comb
  begin
    case (size_q)
      SIZE_BYTE: lane_we = byte_en_t'(4'b0001 << off_q);
      SIZE_HALF: lane_we = off_q[1] ? 4'b1100 : 4'b0011;
      default:   lane_we = 4'b1111;
    endcase
  end

  assign commit = active && write_q && (wait_cnt == '0);

  always_ff @(posedge CLK)
  begin
    if (commit)
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (lane_we[i])
          mem[idx_q][8*i +: 8] <= HWDATA[8*i +: 8];
      end
    end
  end

  assign HREADYOUT = (wait_cnt == '0);   // high when idle or done.
  assign HRDATA    = rdata_q;
  assign HRESP     = RESP_OKAY;          // never fails.

endmodule

// File: logic/ahb_decoder.sv
// ======================================
// AHB-Lite address decoder
// region selects, data-phase response mux
// and a default slave for unmapped space.
// ======================================

`include "ahb_config.svh"

module ahb_decoder
  import ahb_pkg::*;
(
  input  logic     CLK,
  input  logic     nRST,
  input  addr_t    HADDR,
  input  htrans_t  HTRANS,
  input  logic     HREADYOUT0,
  input  logic     HREADYOUT1,
  input  word_t    HRDATA0,
  input  word_t    HRDATA1,
  input  hresp_t   HRESP0,
  input  hresp_t   HRESP1,
  output logic     HSEL0,
  output logic     HSEL1,
  output logic     HREADY,
  output word_t    HRDATA,
  output hresp_t   HRESP
);

  addr_t off0;           // offset into region 0.
  addr_t off1;           // offset into region 1.
  logic  active;         // address phase carries a transfer.
  logic  unmapped;       // transfer outside both regions.
  logic  dsel0;          // slave 0 owns the data phase.
  logic  dsel1;          // slave 1 owns the data phase.
  logic  dsel_def;       // default slave owns the data phase.
  logic  def_first;      // default slave in its first ERROR cycle.

  // ======================================
  // address decode
  // ======================================

  assign off0 = HADDR - addr_t'(`SLAVE0_BASE);
  assign off1 = HADDR - addr_t'(`SLAVE1_BASE);

  assign HSEL0    = (off0 < addr_t'(`REGION_SIZE));   // wraps below base.
  assign HSEL1    = (off1 < addr_t'(`REGION_SIZE));
  assign active   = (HTRANS == TRANS_NONSEQ);
  assign unmapped = active && !HSEL0 && !HSEL1;

  // data-phase owner moves only when the bus is ready.
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      dsel0    <= 1'b0;
      dsel1    <= 1'b0;
      dsel_def <= 1'b0;
    end
    else if (HREADY)
    begin
      dsel0    <= active && HSEL0;
      dsel1    <= active && HSEL1;
      dsel_def <= unmapped;
    end
  end

  // default slave, low HREADY for one cycle then high.
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      def_first <= 1'b0;
    else
      def_first <= HREADY && unmapped;
  end

  // ======================================
  // response mux
  // ======================================

  always_comb
  begin
    HREADY = 1'b1;                   // no owner reads as ready.
    HRDATA = '0;
    HRESP  = RESP_OKAY;
    if (dsel0)
    begin
      HREADY = HREADYOUT0;
      HRDATA = HRDATA0;
      HRESP  = HRESP0;
    end
    else if (dsel1)
    begin
      HREADY = HREADYOUT1;
      HRDATA = HRDATA1;
      HRESP  = HRESP1;
    end
    else if (dsel_def)
    begin
      HREADY = !def_first;           // two-cycle ERROR.
      HRESP  = RESP_ERROR;
    end
  end

endmodule

// File: logic/ahb_master.sv
// ======================================
// AHB-Lite master bridge
// turns a ren/wen memory request into a
// single NONSEQ transfer, holds busy until
// the data phase ends, returns rdata/err.
// ======================================

`include "ahb_config.svh"

module ahb_master
  import ahb_pkg::*;
(
  input  logic          CLK,
  input  logic          nRST,
  // request port.
  input  logic          ren,
  input  logic          wen,
  input  addr_t         addr,
  input  word_t         wdata,
  input  byte_en_t      byte_en,
  output logic          busy,
  output word_t         rdata,
  output logic          err,
  // AHB-Lite master side.
  input  word_t         HRDATA,
  input  logic          HREADY,
  input  hresp_t        HRESP,
  output addr_t         HADDR,
  output htrans_t       HTRANS,
  output logic          HWRITE,
  output hsize_t        HSIZE,
  output word_t         HWDATA
);

  master_state_t state, n_state;

  logic       req_write;   // latched direction.
  addr_t      req_addr;    // latched word address.
  word_t      req_wdata;   // latched write data.
  byte_en_t   req_be;      // latched lane mask.
  logic       err_seen;    // ERROR seen during data phase.
  logic       done;        // data phase completes this cycle.
  logic [1:0] lane_off;    // low address bits from the mask.

  // ======================================
  // state machine
  // ======================================

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      state <= IDLE;
    else
      state <= n_state;
  end

  always_comb
  begin
    n_state = state;
    case (state)
      IDLE:
      begin
        if (ren || wen)
          n_state = ADDR;      // request registered this cycle.
      end
      ADDR:
      begin
        if (HREADY)
          n_state = DATA;      // address accepted.
      end
      DATA:
      begin
        if (HREADY)
          n_state = IDLE;      // transfer finished.
      end
      default:
        n_state = IDLE;
    endcase
  end

  // request latch, taken only when idle.
  always_ff @(posedge CLK)
  begin
    if (state == IDLE && (ren || wen))
    begin
      req_write <= wen;
      req_addr  <= addr;
      req_wdata <= wdata;
      req_be    <= byte_en;
    end
  end

  // first cycle of a two-cycle ERROR has HREADY low, keep it.
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      err_seen <= 1'b0;
    else if (state != DATA)
      err_seen <= 1'b0;
    else if (HRESP == RESP_ERROR)
      err_seen <= 1'b1;
  end

  // ======================================
  // lane mask to size and offset
  // ======================================

  always_comb
  begin
    HSIZE    = SIZE_WORD;
    lane_off = 2'd0;
    case (req_be)
      4'b1111: HSIZE = SIZE_WORD;                   // full word.
      4'b0011: HSIZE = SIZE_HALF;                   // lower half.
      4'b1100:
      begin
        HSIZE    = SIZE_HALF;                       // upper half.
        lane_off = 2'd2;
      end
      4'b0001: HSIZE = SIZE_BYTE;                   // lane 0.
      4'b0010:
      begin
        HSIZE    = SIZE_BYTE;
        lane_off = 2'd1;
      end
      4'b0100:
      begin
        HSIZE    = SIZE_BYTE;
        lane_off = 2'd2;
      end
      4'b1000:
      begin
        HSIZE    = SIZE_BYTE;
        lane_off = 2'd3;
      end
      default: HSIZE = SIZE_WORD;                   // odd masks go as words.
    endcase
  end

  // bus outputs, all from the latch.
  assign HTRANS = (state == ADDR) ? TRANS_NONSEQ : TRANS_IDLE;
  assign HWRITE = (state == ADDR) && req_write;
  assign HADDR  = {req_addr[`AHB_ADDR_W-1:2], lane_off};
  assign HWDATA = req_wdata;                        // held through data phase.

  // requester side.
  assign done  = (state == DATA) && HREADY;
  assign busy  = (ren || wen) && !done;
  assign rdata = HRDATA;                            // valid in completion cycle.
  assign err   = done && (HRESP == RESP_ERROR || err_seen);

endmodule

// File: logic/ahb_pkg.sv
// ======================================
// AHB-Lite subsystem package
// bus vector types, HTRANS/HSIZE/HRESP
// encodings and the master state type.
// ======================================

`include "ahb_config.svh"

package ahb_pkg;

  // bus vectors.
  typedef logic [`AHB_ADDR_W-1:0]     addr_t;     // byte address.
  typedef logic [`AHB_DATA_W-1:0]     word_t;     // data word.
  typedef logic [`AHB_DATA_W/8-1:0]   byte_en_t;  // bit n enables lane n.

  // protocol fields.
  typedef logic [1:0] htrans_t;                   // transfer type.
  typedef logic [2:0] hsize_t;                    // transfer size.
  typedef logic       hresp_t;                    // slave response.

  // HTRANS encodings.
  localparam htrans_t TRANS_IDLE   = 2'b00;       // no transfer.
  localparam htrans_t TRANS_NONSEQ = 2'b10;       // single transfer.

  // HSIZE encodings.
  localparam hsize_t  SIZE_BYTE    = 3'b000;      // 8 bits.
  localparam hsize_t  SIZE_HALF    = 3'b001;      // 16 bits.
  localparam hsize_t  SIZE_WORD    = 3'b010;      // 32 bits.

  // HRESP encodings.
  localparam hresp_t  RESP_OKAY    = 1'b0;        // transfer ok.
  localparam hresp_t  RESP_ERROR   = 1'b1;        // transfer failed.

  // master bridge FSM.
  typedef enum logic [1:0] {
    IDLE,                                         // waiting for a request.
    ADDR,                                         // address phase on the bus.
    DATA                                          // data phase until HREADY.
  } master_state_t;

endpackage

// File: logic/ahb_config.svh
// ======================================
// AHB-Lite subsystem configuration
// bus widths, SRAM depth, the two slave
// regions and their wait-state counts.
// ======================================

`ifndef AHB_CONFIG_SVH
`define AHB_CONFIG_SVH

// bus widths.
`define AHB_ADDR_W    32             // byte address width.
`define AHB_DATA_W    32             // data bus width.

// memory.
`define SRAM_WORDS    256            // words per SRAM slave.

// address map.
`define SLAVE0_BASE   32'h0000_0000  // slave 0 region start.
`define SLAVE1_BASE   32'h0000_1000  // slave 1 region start.
`define REGION_SIZE   32'h0000_1000  // bytes per region.

// wait states per slave.
`define SLAVE0_WAIT   0              // zero-wait SRAM.
`define SLAVE1_WAIT   2              // slow SRAM.

`endif
